// File: sources.f
source/vlsu_cfg_pkg.sv
source/vlsu_bus_pkg.sv
source/vlsu_req_ctrl.sv
source/vlsu_rob.sv
source/vlsu_mem_side.sv
source/vlsu_vrf_side.sv
source/vlsu_top.sv
testbench/tb_mem_model.sv
testbench/tb_vlsu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_vlsu \
  -f sources.f -o tb_vlsu_sim
./obj_dir/tb_vlsu_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: testbench/tb_vlsu.sv
////////////////////
// Directed tests of the vector load/store unit
// Register file is an array of 256 words and memory sits in tb_mem_model
// Outputs are sampled 2 ns after the falling edge, once inputs have settled
////////////////////

`timescale 1ns/10ps

module tb_vlsu;

  localparam int TestCycles    = 200;
  localparam int NrTests       = 6;
  localparam int MaxCycles     = 10 * NrTests * TestCycles;
  // Fewer slots than register words, so the buffer limit is exercised
  localparam int NrOutstanding = 4;

  logic                      clk;
  logic                      reset;
  logic                      heavy;
  vlsu_bus_pkg::vlsu_req_t   req;
  logic                      req_valid, req_ready;
  vlsu_bus_pkg::vlsu_rsp_t   rsp;
  logic                      rsp_valid;
  vlsu_bus_pkg::mem_req_t    mem_req;
  logic                      mem_valid, mem_ready;
  vlsu_bus_pkg::mem_result_t mem_result;
  logic                      mem_result_valid;
  vlsu_cfg_pkg::vrf_addr_t   vrf_waddr, vrf_raddr;
  vlsu_cfg_pkg::word_t       vrf_wdata, vrf_rdata;
  vlsu_cfg_pkg::strb_t       vrf_wbe;
  logic                      vrf_we, vrf_wvalid, vrf_re, vrf_rvalid;

  logic [31:0]             vrf [256];
  vlsu_bus_pkg::vlsu_rsp_t rsp_q [$];
  int cycles, errors, passed, failed, vrf_writes, vrf_reads;

  vlsu_top #(.NrOutstanding(NrOutstanding)) DUT (
    .clk_i (clk), .reset_i (reset),
    .req_i (req), .req_valid_i (req_valid), .req_ready_o (req_ready),
    .rsp_o (rsp), .rsp_valid_o (rsp_valid),
    .mem_req_o (mem_req), .mem_valid_o (mem_valid), .mem_ready_i (mem_ready),
    .mem_result_i (mem_result), .mem_result_valid_i (mem_result_valid),
    .vrf_waddr_o (vrf_waddr), .vrf_wdata_o (vrf_wdata), .vrf_wbe_o (vrf_wbe),
    .vrf_we_o (vrf_we), .vrf_wvalid_i (vrf_wvalid),
    .vrf_raddr_o (vrf_raddr), .vrf_re_o (vrf_re),
    .vrf_rdata_i (vrf_rdata), .vrf_rvalid_i (vrf_rvalid)
  );

  tb_mem_model mem_model (
    .clk_i (clk), .reset_i (reset), .heavy_i (heavy),
    .mem_req_i (mem_req), .mem_valid_i (mem_valid), .mem_ready_o (mem_ready),
    .mem_result_o (mem_result), .mem_result_valid_o (mem_result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Register file port
  ////////////////////

  always @(negedge clk) begin
    if (reset) begin
      vrf_wvalid = 1'b0;
      vrf_rvalid = 1'b0;
      vrf_rdata  = '0;
    end else begin
      vrf_wvalid = ~heavy | cycles[0];
      vrf_rvalid = vrf_re;
      vrf_rdata  = vrf_re ? vrf[vrf_raddr] : '0;
      if (vrf_re) begin
        vrf_reads++;
      end
      if (vrf_we && vrf_wvalid) begin
        vrf_writes++;
        for (int k = 0; k < 4; k++) begin
          if (vrf_wbe[k]) begin
            vrf[vrf_waddr][8*k +: 8] = vrf_wdata[8*k +: 8];
          end
        end
      end
    end
  end

  // Record response pulses once all inputs of the cycle are set
  always @(negedge clk) begin
    #2;
    if (!reset && rsp_valid) begin
      rsp_q.push_back(rsp);
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic send_req(input logic is_load, input vlsu_cfg_pkg::ew_e ew,
                          input int vl, input logic [31:0] base, input int vd,
                          input int id);
    @(negedge clk);
    req.is_load = is_load;
    req.ew      = ew;
    req.vl      = vlsu_cfg_pkg::vl_t'(vl);
    req.base    = base;
    req.vd      = vlsu_cfg_pkg::vreg_t'(vd);
    req.id      = vlsu_bus_pkg::instr_id_t'(id);
    req_valid   = 1'b1;
    #2;
    while (!req_ready) begin
      @(negedge clk);
      #2;
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic expect_rsp(input string name, input int id, input int vd);
    while (rsp_q.size() == 0) begin
      @(negedge clk);
    end
    check_value({name, " rsp id"}, id, rsp_q[0].id);
    check_value({name, " rsp vd"}, vd, rsp_q[0].vd);
    rsp_q.delete(0);
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("test %s finished without errors", name);
    end else begin
      failed++;
      $display("test %s finished with %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic idle_after_reset();
    int e;
    e = errors;
    @(negedge clk);
    #2;
    check_value("reset req_ready", 1, req_ready);
    check_value("reset rsp_valid", 0, rsp_valid);
    check_value("reset mem_valid", 0, mem_valid);
    check_value("reset vrf_we", 0, vrf_we);
    check_value("reset vrf_re", 0, vrf_re);
    end_test("reset_state", e);
  endtask

  task automatic load_words();
    int e;
    e = errors;
    send_req(1'b1, vlsu_cfg_pkg::EW_32, 5, 32'h40, 3, 5);
    expect_rsp("load_ew32", 5, 3);
    for (int w = 0; w < 5; w++) begin
      check_value("load_ew32 data", mem_model.mem[16 + w], vrf[24 + w]);
    end
    end_test("load_ew32", e);
  endtask

  task automatic load_bytes();
    int e;
    logic [31:0] old1;
    e = errors;
    old1 = vrf[57];
    send_req(1'b1, vlsu_cfg_pkg::EW_8, 7, 32'h100, 7, 1);
    expect_rsp("load_ew8", 1, 7);
    check_value("load_ew8 word0", mem_model.mem[64], vrf[56]);
    // Only the low three bytes of word 1 are enabled for seven bytes
    check_value("load_ew8 word1", {old1[31:24], mem_model.mem[65][23:0]}, vrf[57]);
    end_test("load_ew8", e);
  endtask

  task automatic store_halfwords();
    int e;
    int lc;
    logic [31:0] old3;
    e = errors;
    lc = mem_model.last_count;
    old3 = mem_model.mem[131];
    send_req(1'b0, vlsu_cfg_pkg::EW_16, 6, 32'h200, 10, 6);
    expect_rsp("store_ew16", 6, 10);
    for (int w = 0; w < 3; w++) begin
      check_value("store_ew16 data", vrf[80 + w], mem_model.mem[128 + w]);
    end
    check_value("store_ew16 untouched", old3, mem_model.mem[131]);
    check_value("store_ew16 last count", lc + 1, mem_model.last_count);
    check_value("store_ew16 last addr", 32'h208, mem_model.last_addr);
    end_test("store_ew16", e);
  endtask

  task automatic load_under_stalls();
    int e;
    e = errors;
    heavy = 1'b1;
    send_req(1'b1, vlsu_cfg_pkg::EW_32, 8, 32'h300, 20, 3);
    expect_rsp("backpressure", 3, 20);
    heavy = 1'b0;
    for (int w = 0; w < 8; w++) begin
      check_value("backpressure data", mem_model.mem[192 + w], vrf[160 + w]);
    end
    if (mem_model.max_outstanding > NrOutstanding) begin
      $display("memory saw %0d outstanding loads, more than the buffer holds",
               mem_model.max_outstanding);
      errors++;
    end
    end_test("backpressure", e);
  endtask

  task automatic zero_length_request();
    int e;
    int rc, wc, rdc, qc;
    e = errors;
    rc = mem_model.req_count;
    wc = vrf_writes;
    rdc = vrf_reads;
    qc = rsp_q.size();
    send_req(1'b1, vlsu_cfg_pkg::EW_32, 0, 32'h80, 2, 4);
    repeat (20) @(negedge clk);
    check_value("zero_length mem requests", rc, mem_model.req_count);
    check_value("zero_length vrf writes", wc, vrf_writes);
    check_value("zero_length vrf reads", rdc, vrf_reads);
    check_value("zero_length responses", qc, rsp_q.size());
    send_req(1'b1, vlsu_cfg_pkg::EW_32, 2, 32'h80, 1, 2);
    expect_rsp("zero_length next", 2, 1);
    check_value("zero_length next word0", mem_model.mem[32], vrf[8]);
    check_value("zero_length next word1", mem_model.mem[33], vrf[9]);
    end_test("zero_length", e);
  endtask

  initial begin
    cycles     = 0;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    vrf_writes = 0;
    vrf_reads  = 0;
    heavy      = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    vrf_wvalid = 1'b0;
    vrf_rvalid = 1'b0;
    vrf_rdata  = '0;
    for (int i = 0; i < 256; i++) begin
      vrf[i] = {8'(i) + 8'h71, 8'(i) ^ 8'h2d, 8'(i), ~8'(i)};
    end
    reset = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    idle_after_reset();
    load_words();
    load_bytes();
    store_halfwords();
    load_under_stalls();
    zero_length_request();

    $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/tb_mem_model.sv
////////////////////
// Word memory of 256 words behind the memory request port
// Ready drops at random and load results return late and shuffled
// Inputs are sampled and outputs driven on the falling clock edge
////////////////////

`timescale 1ns/10ps

module tb_mem_model (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      heavy_i,
  input  vlsu_bus_pkg::mem_req_t    mem_req_i,
  input  logic                      mem_valid_i,
  output logic                      mem_ready_o,
  output vlsu_bus_pkg::mem_result_t mem_result_o,
  output logic                      mem_result_valid_o
);

  logic [31:0]           mem [256];
  int                    seed;
  int                    cyc;
  vlsu_bus_pkg::mem_id_t pend_id [$];
  logic [31:0]           pend_data [$];
  int                    pend_due [$];
  int                    max_outstanding;
  int                    req_count;
  int                    last_count;
  logic [31:0]           last_addr;

  initial begin
    seed               = 32'h89a3c3d0;
    cyc                = 0;
    max_outstanding    = 0;
    req_count          = 0;
    last_count         = 0;
    last_addr          = '0;
    mem_ready_o        = 1'b0;
    mem_result_o       = '0;
    mem_result_valid_o = 1'b0;
    // Every byte depends on the full word index
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'hc3, 8'(i) + 8'h5e, ~8'(i), 8'(i)};
    end
  end

  // Valid and the request depend on DUT state only, so they are stable here
  always @(negedge clk_i) begin : mem_port
    int elig [$];
    int pick;
    int r;
    int idx;
    cyc++;
    if (reset_i) begin
      mem_ready_o        = 1'b0;
      mem_result_valid_o = 1'b0;
    end else begin
      r = $unsigned($random(seed)) % 4;
      mem_ready_o = heavy_i ? (r == 0) : (r != 0);
      if (mem_valid_i && mem_ready_o) begin
        req_count++;
        idx = mem_req_i.addr[9:2];
        if (mem_req_i.last) begin
          last_count++;
          last_addr = mem_req_i.addr;
        end
        if (mem_req_i.we) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_req_i.strb[k]) begin
              mem[idx][8*k +: 8] = mem_req_i.wdata[8*k +: 8];
            end
          end
        end else begin
          pend_id.push_back(mem_req_i.id);
          pend_data.push_back(mem[idx]);
          pend_due.push_back(cyc + 1 + ($unsigned($random(seed)) % (heavy_i ? 16 : 4)));
          if (pend_id.size() > max_outstanding) begin
            max_outstanding = pend_id.size();
          end
        end
      end
      // Any due result may go next, which shuffles the order
      elig.delete();
      for (int i = 0; i < pend_id.size(); i++) begin
        if (pend_due[i] <= cyc) begin
          elig.push_back(i);
        end
      end
      mem_result_valid_o = 1'b0;
      mem_result_o       = '0;
      if (elig.size() > 0) begin
        pick = elig[$unsigned($random(seed)) % elig.size()];
        mem_result_valid_o    = 1'b1;
        mem_result_o.id       = pend_id[pick];
        mem_result_o.rdata    = pend_data[pick];
        pend_id.delete(pick);
        pend_data.delete(pick);
        pend_due.delete(pick);
      end
    end
  end

endmodule

// File: source/vlsu_top.sv
////////////////////
// Vector load/store unit, unit-stride loads and stores of one register
// One instruction in flight, base address word aligned
// NrOutstanding bounds the loads in flight, power of two up to 16
////////////////////

`timescale 1ns/10ps

module vlsu_top #(
  parameter int unsigned NrOutstanding = 8
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Controller
  input  vlsu_bus_pkg::vlsu_req_t   req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output vlsu_bus_pkg::vlsu_rsp_t   rsp_o,
  output logic                      rsp_valid_o,
  // Memory
  output vlsu_bus_pkg::mem_req_t    mem_req_o,
  output logic                      mem_valid_o,
  input  logic                      mem_ready_i,
  input  vlsu_bus_pkg::mem_result_t mem_result_i,
  input  logic                      mem_result_valid_i,
  // Register file
  output vlsu_cfg_pkg::vrf_addr_t   vrf_waddr_o,
  output vlsu_cfg_pkg::word_t       vrf_wdata_o,
  output vlsu_cfg_pkg::strb_t       vrf_wbe_o,
  output logic                      vrf_we_o,
  input  logic                      vrf_wvalid_i,
  output vlsu_cfg_pkg::vrf_addr_t   vrf_raddr_o,
  output logic                      vrf_re_o,
  input  vlsu_cfg_pkg::word_t       vrf_rdata_i,
  input  logic                      vrf_rvalid_i
);

  vlsu_bus_pkg::vlsu_op_t op;
  logic                   new_op;
  logic                   mem_finished, vrf_finished;
  vlsu_bus_pkg::rob_wr_t  mem_wr, vrf_wr;
  logic                   mem_pop, vrf_pop;
  vlsu_bus_pkg::mem_id_t  rob_alloc_id;
  logic                   rob_full, rob_head_valid;
  vlsu_cfg_pkg::word_t    rob_head_data;

  vlsu_req_ctrl i_req_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .mem_finished_i (mem_finished),
    .vrf_finished_i (vrf_finished),
    .op_o           (op),
    .new_op_o       (new_op),
    .rsp_o          (rsp_o),
    .rsp_valid_o    (rsp_valid_o)
  );

  vlsu_rob #(
    .NrOutstanding (NrOutstanding)
  ) i_rob (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_wr_i     (mem_wr),
    .vrf_wr_i     (vrf_wr),
    .mem_pop_i    (mem_pop),
    .vrf_pop_i    (vrf_pop),
    .new_op_i     (new_op),
    .alloc_id_o   (rob_alloc_id),
    .full_o       (rob_full),
    .head_valid_o (rob_head_valid),
    .head_data_o  (rob_head_data)
  );

  vlsu_mem_side #(
    .NrOutstanding (NrOutstanding)
  ) i_mem_side (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .op_i               (op),
    .new_op_i           (new_op),
    .mem_req_o          (mem_req_o),
    .mem_valid_o        (mem_valid_o),
    .mem_ready_i        (mem_ready_i),
    .mem_result_i       (mem_result_i),
    .mem_result_valid_i (mem_result_valid_i),
    .rob_full_i         (rob_full),
    .rob_head_valid_i   (rob_head_valid),
    .rob_head_data_i    (rob_head_data),
    .rob_alloc_id_i     (rob_alloc_id),
    .rob_wr_o           (mem_wr),
    .rob_pop_o          (mem_pop),
    .finished_o         (mem_finished)
  );

  vlsu_vrf_side i_vrf_side (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .op_i             (op),
    .new_op_i         (new_op),
    .vrf_waddr_o      (vrf_waddr_o),
    .vrf_wdata_o      (vrf_wdata_o),
    .vrf_wbe_o        (vrf_wbe_o),
    .vrf_we_o         (vrf_we_o),
    .vrf_wvalid_i     (vrf_wvalid_i),
    .vrf_raddr_o      (vrf_raddr_o),
    .vrf_re_o         (vrf_re_o),
    .vrf_rdata_i      (vrf_rdata_i),
    .vrf_rvalid_i     (vrf_rvalid_i),
    .rob_full_i       (rob_full),
    .rob_head_valid_i (rob_head_valid),
    .rob_head_data_i  (rob_head_data),
    .rob_alloc_id_i   (rob_alloc_id),
    .rob_wr_o         (vrf_wr),
    .rob_pop_o        (vrf_pop),
    .finished_o       (vrf_finished)
  );

endmodule

// File: source/vlsu_vrf_side.sv
////////////////////
// Register-file side: one word per transfer into or out of register vd
// Loads write the buffer head, stores read the register into the buffer
////////////////////

`timescale 1ns/10ps

module vlsu_vrf_side (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vlsu_bus_pkg::vlsu_op_t  op_i,
  input  logic                    new_op_i,
  output vlsu_cfg_pkg::vrf_addr_t vrf_waddr_o,
  output vlsu_cfg_pkg::word_t     vrf_wdata_o,
  output vlsu_cfg_pkg::strb_t     vrf_wbe_o,
  output logic                    vrf_we_o,
  input  logic                    vrf_wvalid_i,
  output vlsu_cfg_pkg::vrf_addr_t vrf_raddr_o,
  output logic                    vrf_re_o,
  input  vlsu_cfg_pkg::word_t     vrf_rdata_i,
  input  logic                    vrf_rvalid_i,
  input  logic                    rob_full_i,
  input  logic                    rob_head_valid_i,
  input  vlsu_cfg_pkg::word_t     rob_head_data_i,
  input  vlsu_bus_pkg::mem_id_t   rob_alloc_id_i,
  output vlsu_bus_pkg::rob_wr_t   rob_wr_o,
  output logic                    rob_pop_o,
  output logic                    finished_o
);

  vlsu_cfg_pkg::vl_t       cnt_q, cnt, remaining, delta;
  vlsu_cfg_pkg::vrf_addr_t vrf_addr;
  logic                    op_valid, last, hs;

  assign cnt       = new_op_i ? '0 : cnt_q;
  assign remaining = op_i.vl - cnt;
  assign op_valid  = remaining != '0;
  assign last      = op_valid & (remaining <= vlsu_cfg_pkg::vl_t'(vlsu_cfg_pkg::WordBytes));
  assign delta     = last ? remaining : vlsu_cfg_pkg::vl_t'(vlsu_cfg_pkg::WordBytes);

  // Register base plus word index
  assign vrf_addr = vlsu_cfg_pkg::vrf_addr_t'(op_i.vd) *
                    vlsu_cfg_pkg::vrf_addr_t'(vlsu_cfg_pkg::VregWords) +
                    vlsu_cfg_pkg::vrf_addr_t'(cnt >> $clog2(vlsu_cfg_pkg::WordBytes));

  ////////////////////
  // Load write-back
  ////////////////////

  assign vrf_waddr_o = vrf_addr;
  assign vrf_wdata_o = rob_head_data_i;
  assign vrf_we_o    = op_valid & op_i.is_load & rob_head_valid_i;

  always_comb begin
    for (int k = 0; k < vlsu_cfg_pkg::WordBytes; k++) begin
      vrf_wbe_o[k] = vlsu_cfg_pkg::vl_t'(k) < remaining;
    end
  end

  ////////////////////
  // Store read
  ////////////////////

  assign vrf_raddr_o = vrf_addr;
  assign vrf_re_o    = op_valid & ~op_i.is_load & ~rob_full_i;

  // Read data lands in the slot taken in the same cycle
  assign rob_wr_o.alloc = vrf_re_o & vrf_rvalid_i;
  assign rob_wr_o.push  = vrf_re_o & vrf_rvalid_i;
  assign rob_wr_o.id    = rob_alloc_id_i;
  assign rob_wr_o.data  = vrf_rdata_i;

  assign rob_pop_o = vrf_we_o & vrf_wvalid_i;

  assign hs = rob_pop_o | rob_wr_o.push;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= hs ? cnt + delta : cnt;
    end
  end

  assign finished_o = ~op_valid | (last & hs);

endmodule

// File: source/vlsu_mem_side.sv
////////////////////
// Memory side: one word request per transfer, unit stride only
// The base address must be word aligned
// Loads take a buffer slot per request, stores drain the buffer head
////////////////////

`timescale 1ns/10ps

module vlsu_mem_side #(
  parameter int unsigned NrOutstanding = 8
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  vlsu_bus_pkg::vlsu_op_t    op_i,
  input  logic                      new_op_i,
  output vlsu_bus_pkg::mem_req_t    mem_req_o,
  output logic                      mem_valid_o,
  input  logic                      mem_ready_i,
  input  vlsu_bus_pkg::mem_result_t mem_result_i,
  input  logic                      mem_result_valid_i,
  input  logic                      rob_full_i,
  input  logic                      rob_head_valid_i,
  input  vlsu_cfg_pkg::word_t       rob_head_data_i,
  input  vlsu_bus_pkg::mem_id_t     rob_alloc_id_i,
  output vlsu_bus_pkg::rob_wr_t     rob_wr_o,
  output logic                      rob_pop_o,
  output logic                      finished_o
);

  localparam int unsigned IdWidth = $clog2(NrOutstanding);

  vlsu_cfg_pkg::vl_t   cnt_q, cnt, remaining, delta;
  vlsu_cfg_pkg::strb_t strb;
  logic                op_valid, last, hs;

  // Counter restarts at zero in the cycle the new instruction shows up
  assign cnt       = new_op_i ? '0 : cnt_q;
  assign remaining = op_i.vl - cnt;
  assign op_valid  = remaining != '0;
  assign last      = op_valid & (remaining <= vlsu_cfg_pkg::vl_t'(vlsu_cfg_pkg::WordBytes));
  assign delta     = last ? remaining : vlsu_cfg_pkg::vl_t'(vlsu_cfg_pkg::WordBytes);

  // Enable only the bytes still owed
  always_comb begin
    for (int k = 0; k < vlsu_cfg_pkg::WordBytes; k++) begin
      strb[k] = vlsu_cfg_pkg::vl_t'(k) < remaining;
    end
  end

  assign mem_valid_o = op_valid & (op_i.is_load ? ~rob_full_i : rob_head_valid_i);
  assign hs          = mem_valid_o & mem_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= hs ? cnt + delta : cnt;
    end
  end

  always_comb begin
    mem_req_o.addr  = op_i.base + vlsu_cfg_pkg::addr_t'(cnt);
    mem_req_o.we    = ~op_i.is_load;
    mem_req_o.strb  = strb;
    mem_req_o.wdata = op_i.is_load ? '0 : rob_head_data_i;
    mem_req_o.last  = last;
    // Stores carry their word index as id
    mem_req_o.id    = op_i.is_load ? rob_alloc_id_i :
                      vlsu_bus_pkg::mem_id_t'(cnt >> $clog2(vlsu_cfg_pkg::WordBytes));
  end

  // Results come back tagged with the slot taken at request time
  assign rob_wr_o.alloc = op_i.is_load & hs;
  assign rob_wr_o.push  = op_i.is_load & mem_result_valid_i;
  assign rob_wr_o.id    = vlsu_bus_pkg::mem_id_t'(mem_result_i.id[IdWidth-1:0]);
  assign rob_wr_o.data  = mem_result_i.rdata;

  assign rob_pop_o  = ~op_i.is_load & hs;
  assign finished_o = ~op_valid | (last & hs);

endmodule

// File: source/vlsu_rob.sv
////////////////////
// Reorder buffer between the memory side and the register-file side
// Slots are allocated in order, filled by id in any order, freed from the head
// Only one side writes per instruction, so the two write ports are merged
// NrOutstanding must be a power of two between 2 and 16
////////////////////

`timescale 1ns/10ps

module vlsu_rob #(
  parameter int unsigned NrOutstanding = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  vlsu_bus_pkg::rob_wr_t mem_wr_i,
  input  vlsu_bus_pkg::rob_wr_t vrf_wr_i,
  input  logic                  mem_pop_i,
  input  logic                  vrf_pop_i,
  input  logic                  new_op_i,
  output vlsu_bus_pkg::mem_id_t alloc_id_o,
  output logic                  full_o,
  output logic                  head_valid_o,
  output vlsu_cfg_pkg::word_t   head_data_o
);

  localparam int unsigned IdWidth = $clog2(NrOutstanding);

  // One extra bit tells full from empty
  typedef logic [IdWidth:0] ptr_t;

  vlsu_bus_pkg::rob_wr_t    wr;
  logic                     pop;
  ptr_t                     alloc_q, alloc_base, alloc_d;
  ptr_t                     head_q, head_base, head_d;
  logic [NrOutstanding-1:0] valid_q, valid_base, valid_d;
  logic [IdWidth-1:0]       wr_idx, head_idx;
  vlsu_cfg_pkg::word_t      slot_data [NrOutstanding];

  // The side that owns the instruction drives the write port
  assign wr  = (mem_wr_i.alloc | mem_wr_i.push) ? mem_wr_i : vrf_wr_i;
  assign pop = mem_pop_i | vrf_pop_i;

  // A new instruction starts from slot 0; the side may allocate in that cycle
  assign alloc_base = new_op_i ? '0 : alloc_q;
  assign head_base  = new_op_i ? '0 : head_q;
  assign valid_base = new_op_i ? '0 : valid_q;

  assign wr_idx   = wr.id[IdWidth-1:0];
  assign head_idx = head_base[IdWidth-1:0];

  always_comb begin
    alloc_d = alloc_base + ptr_t'(wr.alloc);
    head_d  = head_base + ptr_t'(pop);
    valid_d = valid_base;
    if (pop) begin
      valid_d[head_idx] = 1'b0;
    end
    if (wr.push) begin
      valid_d[wr_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alloc_q <= '0;
      head_q  <= '0;
      valid_q <= '0;
    end else begin
      alloc_q <= alloc_d;
      head_q  <= head_d;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr.push) begin
      slot_data[wr_idx] <= wr.data;
    end
  end

  assign alloc_id_o   = vlsu_bus_pkg::mem_id_t'(alloc_base[IdWidth-1:0]);
  assign full_o       = (alloc_base - head_base) == ptr_t'(NrOutstanding);
  assign head_valid_o = valid_base[head_idx];
  assign head_data_o  = slot_data[head_idx];

endmodule

// File: source/vlsu_req_ctrl.sv
////////////////////
// Accepts one instruction at a time and holds it until both sides finish
// A zero-length instruction is taken but never answered
////////////////////

`timescale 1ns/10ps

module vlsu_req_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vlsu_bus_pkg::vlsu_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic                    mem_finished_i,
  input  logic                    vrf_finished_i,
  output vlsu_bus_pkg::vlsu_op_t  op_o,
  output logic                    new_op_o,
  output vlsu_bus_pkg::vlsu_rsp_t rsp_o,
  output logic                    rsp_valid_o
);

  vlsu_bus_pkg::vlsu_op_t op_q, op_d;
  logic                   accept;
  logic                   done;
  logic                   new_op_q;

  assign req_ready_o = mem_finished_i & vrf_finished_i;
  assign accept      = req_valid_i & req_ready_o;
  assign done        = req_ready_o & (op_q.vl != '0);

  always_comb begin
    op_d = op_q;
    if (accept) begin
      op_d.is_load = req_i.is_load;
      op_d.base    = req_i.base;
      op_d.vd      = req_i.vd;
      op_d.id      = req_i.id;
      // Element count to byte count
      unique case (req_i.ew)
        vlsu_cfg_pkg::EW_8:  op_d.vl = req_i.vl;
        vlsu_cfg_pkg::EW_16: op_d.vl = req_i.vl << 1;
        vlsu_cfg_pkg::EW_32: op_d.vl = req_i.vl << 2;
        default:             op_d.vl = '0;
      endcase
    end else if (done) begin
      // Drop back to idle when nothing new is taken
      op_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_q     <= '0;
      new_op_q <= 1'b0;
    end else begin
      op_q     <= op_d;
      // Both side counters restart on a new or a cleared instruction
      new_op_q <= accept | done;
    end
  end

  assign op_o     = op_q;
  assign new_op_o = new_op_q;

  assign rsp_o.id    = op_q.id;
  assign rsp_o.vd    = op_q.vd;
  assign rsp_valid_o = done;

endmodule

// File: source/vlsu_bus_pkg.sv
////////////////////
// Packed structs for requests, responses, memory and reorder-buffer traffic
// Memory ids are 4 bits, enough for a reorder buffer of up to 16 slots
////////////////////

package vlsu_bus_pkg;

  typedef logic [2:0] instr_id_t;
  typedef logic [3:0] mem_id_t;

  // Request from the controller, vl counted in elements
  typedef struct packed {
    logic                  is_load;
    vlsu_cfg_pkg::ew_e     ew;
    vlsu_cfg_pkg::vl_t     vl;
    vlsu_cfg_pkg::addr_t   base;
    vlsu_cfg_pkg::vreg_t   vd;
    instr_id_t             id;
  } vlsu_req_t;

  // Held instruction, vl already in bytes
  typedef struct packed {
    logic                  is_load;
    vlsu_cfg_pkg::vl_t     vl;
    vlsu_cfg_pkg::addr_t   base;
    vlsu_cfg_pkg::vreg_t   vd;
    instr_id_t             id;
  } vlsu_op_t;

  typedef struct packed {
    instr_id_t             id;
    vlsu_cfg_pkg::vreg_t   vd;
  } vlsu_rsp_t;

  typedef struct packed {
    mem_id_t               id;
    vlsu_cfg_pkg::addr_t   addr;
    logic                  we;
    vlsu_cfg_pkg::strb_t   strb;
    vlsu_cfg_pkg::word_t   wdata;
    logic                  last;
  } mem_req_t;

  typedef struct packed {
    mem_id_t               id;
    vlsu_cfg_pkg::word_t   rdata;
  } mem_result_t;

  // alloc takes the next slot in order, push fills the slot named by id
  typedef struct packed {
    logic                  alloc;
    logic                  push;
    mem_id_t               id;
    vlsu_cfg_pkg::word_t   data;
  } rob_wr_t;

endpackage

// File: source/vlsu_cfg_pkg.sv
////////////////////
// Sizes and scalar types of the vector load/store unit
// One memory word and one register-file word are both WordBytes wide
// Counts are byte counts once an instruction is held, at most one register
////////////////////

package vlsu_cfg_pkg;

  localparam int unsigned WordBytes = 4;
  localparam int unsigned VregWords = 8;
  localparam int unsigned NrVregs   = 32;

  typedef logic [8*WordBytes-1:0] word_t;
  typedef logic [WordBytes-1:0]   strb_t;
  typedef logic [31:0]            addr_t;

  // Holds a full register in bytes, so one bit above the byte index
  typedef logic [$clog2(VregWords*WordBytes):0]       vl_t;
  typedef logic [$clog2(NrVregs)-1:0]                 vreg_t;
  typedef logic [$clog2(NrVregs*VregWords)-1:0]       vrf_addr_t;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } ew_e;

endpackage
